// File: Makefile
# Verilator build and run of the biquad IIR test system

VERILATOR ?= verilator
TOP       ?= tb_iir_biquad_system
LINT_TOP  ?= iir_biquad_system
FILELIST  ?= iir_biquad_system.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

# the log decides the result, not the exit status of the simulator
run: build
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/iir_biquad_apb_regs.sv
`default_nettype none

module iir_biquad_apb_regs (
  // clock and reset
  input  wire                                            clk,
  input  wire                                            rst_n,

  // APB3 slave
  input  wire  [iir_sys_pkg::APB_ADDR_WIDTH_C-1:0]       apb_paddr,
  input  wire                                            apb_psel,
  input  wire                                            apb_penable,
  input  wire                                            apb_pwrite,
  input  wire  [iir_sys_pkg::APB_DATA_WIDTH_C-1:0]       apb_pwdata,
  output logic                                           apb_pready,
  output logic [iir_sys_pkg::APB_DATA_WIDTH_C-1:0]       apb_prdata,

  // status in, configuration out
  input  wire  iir_sys_pkg::sample_t                     y,
  output iir_sys_pkg::iir_cfg_t                          cfg
);

  import iir_sys_pkg::*;

  logic access; // second phase of a transfer
  logic wr_en;

  assign access     = apb_psel && apb_penable;
  assign wr_en      = access && apb_pwrite;
  assign apb_pready = access; // no wait states

  ////////////////////////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= CFG_RESET_C;
    end else if (wr_en) begin
      case (apb_paddr)
        REG_CTRL_O:     cfg.bypass   <= apb_pwdata[0];
        REG_OSC_STEP_O: cfg.osc_step <= apb_pwdata[PHASE_WIDTH_C-1:0];
        REG_FS_DIV_O:   cfg.fs_div   <= apb_pwdata;
        REG_B0_O:       cfg.coefs.b0 <= apb_pwdata[COEF_WIDTH_C-1:0]; // low bits kept
        REG_B1_O:       cfg.coefs.b1 <= apb_pwdata[COEF_WIDTH_C-1:0];
        REG_B2_O:       cfg.coefs.b2 <= apb_pwdata[COEF_WIDTH_C-1:0];
        REG_A1_O:       cfg.coefs.a1 <= apb_pwdata[COEF_WIDTH_C-1:0];
        REG_A2_O:       cfg.coefs.a2 <= apb_pwdata[COEF_WIDTH_C-1:0];
        default: begin
          // REG_Y_O and unmapped offsets ignore writes
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // readback
  ////////////////////////////////////////////////////////////

  always_comb begin
    apb_prdata = '0;
    if (access) begin
      case (apb_paddr)
        REG_CTRL_O:     apb_prdata[0] = cfg.bypass;
        REG_OSC_STEP_O: apb_prdata = APB_DATA_WIDTH_C'(cfg.osc_step);
        REG_FS_DIV_O:   apb_prdata = cfg.fs_div;
        REG_B0_O:       apb_prdata = APB_DATA_WIDTH_C'(cfg.coefs.b0); // sign extended
        REG_B1_O:       apb_prdata = APB_DATA_WIDTH_C'(cfg.coefs.b1);
        REG_B2_O:       apb_prdata = APB_DATA_WIDTH_C'(cfg.coefs.b2);
        REG_A1_O:       apb_prdata = APB_DATA_WIDTH_C'(cfg.coefs.a1);
        REG_A2_O:       apb_prdata = APB_DATA_WIDTH_C'(cfg.coefs.a2);
        REG_Y_O:        apb_prdata = APB_DATA_WIDTH_C'(y);            // last filter output
        default:        apb_prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/iir_biquad_filter.sv
`default_nettype none

module iir_biquad_filter #(
  parameter int Q_BITS_P = iir_sys_pkg::Q_BITS_C // fractional bits of the coefficients
)(
  // clock and reset
  input  wire                         clk,
  input  wire                         rst_n,

  // configuration
  input  wire  iir_sys_pkg::iir_cfg_t cfg,

  // input sample
  input  wire  iir_sys_pkg::sample_t  waveform,
  input  wire                         sample_en,

  // output sample
  output iir_sys_pkg::sample_t        filtered_waveform,
  output logic                        y_valid
);

  import iir_sys_pkg::*;

  // five products of sample by coefficient need three guard bits
  localparam int PROD_WIDTH_C = WAVE_WIDTH_C + COEF_WIDTH_C;
  localparam int ACC_WIDTH_C  = PROD_WIDTH_C + 3;

  localparam sample_t SAMPLE_MAX_C = {1'b0, {(WAVE_WIDTH_C-1){1'b1}}};
  localparam sample_t SAMPLE_MIN_C = {1'b1, {(WAVE_WIDTH_C-1){1'b0}}};

  sample_t x;
  sample_t x1;
  sample_t x2;
  sample_t y1;
  sample_t y2;
  sample_t y_sat;
  sample_t y_next;

  logic signed [ACC_WIDTH_C-1:0] acc;
  logic signed [ACC_WIDTH_C-1:0] acc_shift;

  assign x = waveform; // sampled when sample_en is high

  ////////////////////////////////////////////////////////////
  // direct form I datapath
  ////////////////////////////////////////////////////////////

  // all operands signed, so every term is sign extended to the accumulator
  always_comb begin
    acc = cfg.coefs.b0 * x
        + cfg.coefs.b1 * x1
        + cfg.coefs.b2 * x2
        - cfg.coefs.a1 * y1
        - cfg.coefs.a2 * y2;
  end

  assign acc_shift = acc >>> Q_BITS_P; // floor rounding

  // saturate back to one sample
  always_comb begin
    if (acc_shift > ACC_WIDTH_C'(SAMPLE_MAX_C)) begin
      y_sat = SAMPLE_MAX_C;
    end else if (acc_shift < ACC_WIDTH_C'(SAMPLE_MIN_C)) begin
      y_sat = SAMPLE_MIN_C;
    end else begin
      y_sat = acc_shift[WAVE_WIDTH_C-1:0];
    end
  end

  assign y_next = cfg.bypass ? x : y_sat;

  ////////////////////////////////////////////////////////////
  // histories and output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x1                <= '0;
      x2                <= '0;
      y1                <= '0;
      y2                <= '0;
      filtered_waveform <= '0;
      y_valid           <= 1'b0;
    end else begin
      y_valid <= sample_en; // one cycle after the strobe
      if (sample_en) begin
        x1                <= x;
        x2                <= x1;
        y1                <= y_next; // bypass output also feeds back
        y2                <= y1;
        filtered_waveform <= y_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/iir_biquad_system.sv
`default_nettype none

module iir_biquad_system #(
  parameter int Q_BITS_P = iir_sys_pkg::Q_BITS_C // passed on to the filter
)(
  // clock and reset
  input  wire                                        clk,
  input  wire                                        rst_n,

  // APB3 slave
  input  wire  [iir_sys_pkg::APB_ADDR_WIDTH_C-1:0]   apb_paddr,
  input  wire                                        apb_psel,
  input  wire                                        apb_penable,
  input  wire                                        apb_pwrite,
  input  wire  [iir_sys_pkg::APB_DATA_WIDTH_C-1:0]   apb_pwdata,
  output logic                                       apb_pready,
  output logic [iir_sys_pkg::APB_DATA_WIDTH_C-1:0]   apb_prdata,

  // filtered output
  output iir_sys_pkg::sample_t                       filtered_waveform,
  output logic                                       y_valid
);

  import iir_sys_pkg::*;

  iir_cfg_t cfg;       // configuration from the register block
  sample_t  waveform;  // oscillator output
  logic     sample_en; // sample strobe

  ////////////////////////////////////////////////////////////
  // instances
  ////////////////////////////////////////////////////////////

  iir_biquad_apb_regs iir_biquad_apb_regs_i0 (
    .clk         ( clk               ), // input
    .rst_n       ( rst_n             ), // input
    .apb_paddr   ( apb_paddr         ), // input
    .apb_psel    ( apb_psel          ), // input
    .apb_penable ( apb_penable       ), // input
    .apb_pwrite  ( apb_pwrite        ), // input
    .apb_pwdata  ( apb_pwdata        ), // input
    .apb_pready  ( apb_pready        ), // output
    .apb_prdata  ( apb_prdata        ), // output
    .y           ( filtered_waveform ), // input
    .cfg         ( cfg               )  // output
  );

  oscillator oscillator_i0 (
    .clk      ( clk      ), // input
    .rst_n    ( rst_n    ), // input
    .cfg      ( cfg      ), // input
    .waveform ( waveform )  // output
  );

  sampling_enable sampling_enable_i0 (
    .clk       ( clk       ), // input
    .rst_n     ( rst_n     ), // input
    .cfg       ( cfg       ), // input
    .sample_en ( sample_en )  // output
  );

  iir_biquad_filter #(
    .Q_BITS_P          ( Q_BITS_P          )
  ) iir_biquad_filter_i0 (
    .clk               ( clk               ), // input
    .rst_n             ( rst_n             ), // input
    .cfg               ( cfg               ), // input
    .waveform          ( waveform          ), // input
    .sample_en         ( sample_en         ), // input
    .filtered_waveform ( filtered_waveform ), // output
    .y_valid           ( y_valid           )  // output
  );

endmodule

`default_nettype wire

// File: design/iir_sys_pkg.sv
`default_nettype none

package iir_sys_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int WAVE_WIDTH_C     = 16; // waveform and sample width
  localparam int PHASE_WIDTH_C    = 32; // oscillator accumulator
  localparam int APB_ADDR_WIDTH_C = 8;
  localparam int APB_DATA_WIDTH_C = 32;
  localparam int COEF_WIDTH_C     = 18;
  localparam int Q_BITS_C         = 14; // fractional bits of a coefficient

  `include "iir_regmap.svh"

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic signed [WAVE_WIDTH_C-1:0] sample_t;
  typedef logic signed [COEF_WIDTH_C-1:0] coef_t;

  typedef struct packed {
    coef_t b0; // feed-forward
    coef_t b1;
    coef_t b2;
    coef_t a1; // feedback, subtracted
    coef_t a2;
  } biquad_coefs_t;

  typedef struct packed {
    logic                        bypass;
    logic [PHASE_WIDTH_C-1:0]    osc_step; // added to phase every cycle
    logic [APB_DATA_WIDTH_C-1:0] fs_div;   // sample period in cycles
    biquad_coefs_t               coefs;
  } iir_cfg_t;

  // reset defaults
  localparam logic                        BYPASS_RESET_C   = 1'b1;
  localparam logic [PHASE_WIDTH_C-1:0]    OSC_STEP_RESET_C = 32'h0100_0000;
  localparam logic [APB_DATA_WIDTH_C-1:0] FS_DIV_RESET_C   = 4;
  localparam coef_t                       COEF_RESET_C     = '0;

  localparam iir_cfg_t CFG_RESET_C = '{
    bypass:   BYPASS_RESET_C,
    osc_step: OSC_STEP_RESET_C,
    fs_div:   FS_DIV_RESET_C,
    coefs:    '{b0: COEF_RESET_C, b1: COEF_RESET_C, b2: COEF_RESET_C,
                a1: COEF_RESET_C, a2: COEF_RESET_C}
  };

endpackage

`default_nettype wire

// File: design/oscillator.sv
`default_nettype none

module oscillator (
  // clock and reset
  input  wire                    clk,
  input  wire                    rst_n,

  // configuration
  input  wire  iir_sys_pkg::iir_cfg_t cfg,

  // test waveform
  output iir_sys_pkg::sample_t   waveform
);

  import iir_sys_pkg::*;

  logic [PHASE_WIDTH_C-1:0] phase;

  ////////////////////////////////////////////////////////////
  // phase accumulator
  ////////////////////////////////////////////////////////////

  // wraps on overflow, so the output is a sawtooth
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= '0;
    end else begin
      phase <= phase + cfg.osc_step; // new step applies from the next edge
    end
  end

  // top bits of the phase, read as two's complement
  assign waveform = $signed(phase[PHASE_WIDTH_C-1 -: WAVE_WIDTH_C]);

endmodule

`default_nettype wire

// File: design/sampling_enable.sv
`default_nettype none

module sampling_enable (
  // clock and reset
  input  wire                         clk,
  input  wire                         rst_n,

  // configuration
  input  wire  iir_sys_pkg::iir_cfg_t cfg,

  // one-cycle sample strobe
  output logic                        sample_en
);

  import iir_sys_pkg::*;

  logic [APB_DATA_WIDTH_C-1:0] count;
  logic [APB_DATA_WIDTH_C:0]   count_inc; // one bit wider, never overflows
  logic                        wrap;

  assign count_inc = {1'b0, count} + 1'b1;

  // greater-or-equal so a shortened period is picked up at once,
  // fs_div of 0 behaves like 1
  assign wrap = (count_inc >= {1'b0, cfg.fs_div});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count     <= '0;
      sample_en <= 1'b0;
    end else begin
      sample_en <= wrap;                     // strobe in the cycle after wrap
      count     <= wrap ? '0 : count_inc[APB_DATA_WIDTH_C-1:0];
    end
  end

endmodule

`default_nettype wire

// File: iir_biquad_system.f
+incdir+include
design/iir_sys_pkg.sv
design/iir_biquad_apb_regs.sv
design/oscillator.sv
design/sampling_enable.sv
design/iir_biquad_filter.sv
design/iir_biquad_system.sv
tb/iir_biquad_system_sva.sv
tb/tb_iir_biquad_system.sv

// File: include/iir_regmap.svh
`ifndef IIR_REGMAP_SVH
`define IIR_REGMAP_SVH

////////////////////////////////////////////////////////////
// register offsets of the biquad APB slave
////////////////////////////////////////////////////////////

localparam logic [APB_ADDR_WIDTH_C-1:0] REG_CTRL_O     = 'h00; // bit 0 is bypass
localparam logic [APB_ADDR_WIDTH_C-1:0] REG_OSC_STEP_O = 'h04; // phase step
localparam logic [APB_ADDR_WIDTH_C-1:0] REG_FS_DIV_O   = 'h08; // sampling period
localparam logic [APB_ADDR_WIDTH_C-1:0] REG_B0_O       = 'h0C;
localparam logic [APB_ADDR_WIDTH_C-1:0] REG_B1_O       = 'h10;
localparam logic [APB_ADDR_WIDTH_C-1:0] REG_B2_O       = 'h14;
localparam logic [APB_ADDR_WIDTH_C-1:0] REG_A1_O       = 'h18;
localparam logic [APB_ADDR_WIDTH_C-1:0] REG_A2_O       = 'h1C;
localparam logic [APB_ADDR_WIDTH_C-1:0] REG_Y_O        = 'h20; // read only

`endif

// File: tb/iir_biquad_system_sva.sv
`default_nettype none

module iir_biquad_system_sva (
  input wire                        clk,
  input wire                        rst_n,
  input wire                        apb_psel,
  input wire                        apb_penable,
  input wire                        apb_pready,
  input wire iir_sys_pkg::sample_t  filtered_waveform,
  input wire                        y_valid,
  input wire iir_sys_pkg::iir_cfg_t cfg
);

  logic slow_rate; // sample period longer than one cycle

  assign slow_rate = (cfg.fs_div > 1);

  // zero wait states, ready only in the access phase
  pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    apb_pready |-> (apb_psel && apb_penable))
    else $error("pready high outside an APB access phase");

  known_output: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(filtered_waveform))
    else $error("filtered_waveform has unknown bits");

  // a strobe issued under the previous period can still trail a change
  single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    (y_valid && slow_rate && $past(slow_rate) && $past(slow_rate, 2)) |=> !y_valid)
    else $error("y_valid high for two cycles with fs_div above 1");

endmodule

bind iir_biquad_system iir_biquad_system_sva iir_biquad_system_sva_inst (.*);

`default_nettype wire

// File: tb/tb_iir_biquad_system.sv
`default_nettype none

module tb_iir_biquad_system;

  import iir_sys_pkg::*;

  localparam int FRAC_BITS_C     = Q_BITS_C;
  localparam int MAX_FS_DIV_C    = 12;
  localparam int PERIOD_RUNS_C   = 6;
  localparam int PERIOD_PULSES_C = 8;
  localparam int FILTER_RUNS_C   = 4;
  localparam int SAMPLES_C       = 16; // checked outputs per run
  localparam int CYCLE_LIMIT_C   = (PERIOD_RUNS_C + FILTER_RUNS_C + 1) * (SAMPLES_C + 2)
                                   * MAX_FS_DIV_C + 2000; // margin for APB traffic
  localparam longint SAT_MAX_C   = (longint'(1) <<< (WAVE_WIDTH_C - 1)) - 1;
  localparam longint SAT_MIN_C   = -(longint'(1) <<< (WAVE_WIDTH_C - 1));

  localparam logic [APB_ADDR_WIDTH_C-1:0] CFG_OFFSETS_C [8] = '{
    REG_CTRL_O, REG_OSC_STEP_O, REG_FS_DIV_O, REG_B0_O,
    REG_B1_O, REG_B2_O, REG_A1_O, REG_A2_O
  };

  logic                        clk;
  logic                        rst_n;
  logic [APB_ADDR_WIDTH_C-1:0] apb_paddr;
  logic                        apb_psel;
  logic                        apb_penable;
  logic                        apb_pwrite;
  logic [APB_DATA_WIDTH_C-1:0] apb_pwdata;
  logic                        apb_pready;
  logic [APB_DATA_WIDTH_C-1:0] apb_prdata;
  sample_t                     filtered_waveform;
  logic                        y_valid;

  logic [31:0] lfsr;
  int          errors;
  int          tests_run;
  int          tests_failed;

  // reference model state, updated with nonblocking assignments like the DUT
  logic        m_bypass;
  logic [31:0] m_step;
  logic [31:0] m_fs_div;
  longint      m_coef [5]; // b0 b1 b2 a1 a2
  logic [31:0] m_phase;
  longint      m_count;
  logic        m_sample_en;
  logic        m_y_valid;
  longint      m_x1;
  longint      m_x2;
  longint      m_y1;
  longint      m_y2;
  longint      m_y;
  longint      m_x_last;   // oscillator sample taken at the last strobe

  iir_biquad_system #(
    .Q_BITS_P          ( FRAC_BITS_C       )
  ) iir_biquad_system_inst (
    .clk               ( clk               ),
    .rst_n             ( rst_n             ),
    .apb_paddr         ( apb_paddr         ),
    .apb_psel          ( apb_psel          ),
    .apb_penable       ( apb_penable       ),
    .apb_pwrite        ( apb_pwrite        ),
    .apb_pwdata        ( apb_pwdata        ),
    .apb_pready        ( apb_pready        ),
    .apb_prdata        ( apb_prdata        ),
    .filtered_waveform ( filtered_waveform ),
    .y_valid           ( y_valid           )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int width);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < width; i++) begin
      lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  function automatic logic [31:0] rand_coef(input int width);
    logic [31:0] value;
    value = rand_bits(width);
    if (value[width-1]) value = value | (~32'b0 << width); // sign extend
    return value;
  endfunction

  function automatic longint coef_value(input logic [31:0] w);
    return longint'($signed(w[COEF_WIDTH_C-1:0]));
  endfunction

  function automatic longint wave_of(input logic [31:0] phase);
    return longint'($signed(phase[PHASE_WIDTH_C-1 -: WAVE_WIDTH_C]));
  endfunction

  function automatic longint saturate(input longint v);
    if (v > SAT_MAX_C) return SAT_MAX_C;
    if (v < SAT_MIN_C) return SAT_MIN_C;
    return v;
  endfunction

  // expected readback of a written config register
  function automatic logic [31:0] readback_of(input logic [7:0] addr, input logic [31:0] w);
    case (addr)
      REG_CTRL_O:                   return {31'b0, w[0]};
      REG_OSC_STEP_O, REG_FS_DIV_O: return w;
      default:                      return 32'(coef_value(w)); // coefficients
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s read %08h, expected %08h", $time, what, got, exp);
      errors++;
    end
  endtask

  // one APB3 transfer; also returns the model output at the access edge
  task automatic apb_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic [31:0] y_model);
    @(negedge clk);
    apb_paddr   = addr;
    apb_pwrite  = write;
    apb_pwdata  = wdata;
    apb_psel    = 1'b1;
    apb_penable = 1'b0;
    @(negedge clk);
    apb_penable = 1'b1;
    @(posedge clk); // zero wait states, so this edge ends the access
    assert (apb_pready) else begin
      $display("MISMATCH at %0t: pready low in the access phase at offset %02h",
               $time, addr);
      errors++;
    end
    rdata   = apb_prdata;
    y_model = 32'(m_y);
    @(negedge clk);
    apb_psel    = 1'b0;
    apb_penable = 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic [31:0] y_model;
    apb_transfer(1'b1, addr, data, rdata, y_model);
  endtask

  // cycles from the previous posedge to the next strobe
  task automatic wait_valid(output int n);
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!y_valid && n < 2 * MAX_FS_DIV_C + 8);
    assert (y_valid) else begin
      $display("no y_valid strobe within %0d cycles", n);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors) begin
      $display("test %-16s ok", name);
    end else begin
      tests_failed++;
      $display("test %-16s FAIL with %0d errors", name, errors - start_errors);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model and output compare
  ////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin : model
    longint x;
    longint acc;
    longint y_next;
    longint fs;
    if (!rst_n) begin
      m_bypass    <= BYPASS_RESET_C;
      m_step      <= OSC_STEP_RESET_C;
      m_fs_div    <= FS_DIV_RESET_C;
      m_coef      <= '{default: 0};
      m_phase     <= '0;
      m_count     <= 0;
      m_sample_en <= 1'b0;
      m_y_valid   <= 1'b0;
      m_x1        <= 0;
      m_x2        <= 0;
      m_y1        <= 0;
      m_y2        <= 0;
      m_y         <= 0;
      m_x_last    <= 0;
    end else begin
      assert (y_valid === m_y_valid && filtered_waveform === sample_t'(m_y)) else begin
        $display("MISMATCH at %0t: y_valid %0b expected %0b, output %0d expected %0d",
                 $time, y_valid, m_y_valid, filtered_waveform, m_y);
        errors++;
      end
      x  = wave_of(m_phase);
      fs = m_fs_div;
      m_phase <= m_phase + m_step;
      if (m_count + 1 >= fs) begin // period reached, strobe next cycle
        m_count     <= 0;
        m_sample_en <= 1'b1;
      end else begin
        m_count     <= m_count + 1;
        m_sample_en <= 1'b0;
      end
      m_y_valid <= m_sample_en;
      if (m_sample_en) begin
        acc = m_coef[0] * x + m_coef[1] * m_x1 + m_coef[2] * m_x2
            - m_coef[3] * m_y1 - m_coef[4] * m_y2;
        y_next = m_bypass ? x : saturate(acc >>> FRAC_BITS_C); // floor shift
        m_x1     <= x;
        m_x2     <= m_x1;
        m_y1     <= y_next;
        m_y2     <= m_y1;
        m_y      <= y_next;
        m_x_last <= x;
      end
      if (apb_psel && apb_penable && apb_pwrite) begin
        case (apb_paddr)
          REG_CTRL_O:     m_bypass  <= apb_pwdata[0];
          REG_OSC_STEP_O: m_step    <= apb_pwdata;
          REG_FS_DIV_O:   m_fs_div  <= apb_pwdata;
          REG_B0_O:       m_coef[0] <= coef_value(apb_pwdata);
          REG_B1_O:       m_coef[1] <= coef_value(apb_pwdata);
          REG_B2_O:       m_coef[2] <= coef_value(apb_pwdata);
          REG_A1_O:       m_coef[3] <= coef_value(apb_pwdata);
          REG_A2_O:       m_coef[4] <= coef_value(apb_pwdata);
          default: ;
        endcase
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT_C) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run still going after %0d cycles", CYCLE_LIMIT_C);
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] got;
    logic [31:0] y_model;
    logic [31:0] y_first;
    logic [31:0] wdata;
    int          fs;
    int          n;
    int          start;
    lfsr         = 32'h533e3e86;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    apb_paddr    = '0;
    apb_psel     = 1'b0;
    apb_penable  = 1'b0;
    apb_pwrite   = 1'b0;
    apb_pwdata   = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    start = errors; // reset defaults
    @(posedge clk);
    check_value("y_valid after reset", 32'(y_valid), 32'h0);
    check_value("output after reset", 32'(filtered_waveform), 32'h0);
    apb_transfer(1'b0, REG_CTRL_O, '0, got, y_model);
    check_value("ctrl", got, {31'b0, BYPASS_RESET_C});
    apb_transfer(1'b0, REG_OSC_STEP_O, '0, got, y_model);
    check_value("osc_step", got, OSC_STEP_RESET_C);
    apb_transfer(1'b0, REG_FS_DIV_O, '0, got, y_model);
    check_value("fs_div", got, FS_DIV_RESET_C);
    for (int i = 3; i < 8; i++) begin
      apb_transfer(1'b0, CFG_OFFSETS_C[i], '0, got, y_model);
      check_value($sformatf("coef at %02h", CFG_OFFSETS_C[i]), got, 32'(COEF_RESET_C));
    end
    finish_test("reset_defaults", start);

    start = errors; // register access
    for (int i = 0; i < 8; i++) begin
      wdata = rand_bits(32);
      reg_write(CFG_OFFSETS_C[i], wdata);
      apb_transfer(1'b0, CFG_OFFSETS_C[i], '0, got, y_model);
      check_value($sformatf("offset %02h", CFG_OFFSETS_C[i]), got,
                  readback_of(CFG_OFFSETS_C[i], wdata));
    end
    reg_write(REG_FS_DIV_O, 32'hFFFF_FFF0); // park the strobe so y holds
    apb_transfer(1'b0, REG_Y_O, '0, y_first, y_model);
    check_value("y", y_first, y_model);
    reg_write(REG_Y_O, rand_bits(32));
    apb_transfer(1'b0, REG_Y_O, '0, got, y_model);
    check_value("y after write", got, y_first);
    check_value("y model after write", got, y_model);
    apb_transfer(1'b0, 8'h24, '0, got, y_model);
    check_value("unmapped 24", got, 32'h0);
    apb_transfer(1'b0, 8'h02, '0, got, y_model);
    check_value("unmapped 02", got, 32'h0);
    apb_transfer(1'b0, 8'hFC, '0, got, y_model);
    check_value("unmapped fc", got, 32'h0);
    finish_test("register_access", start);

    start = errors; // sampling period
    for (int r = 0; r < PERIOD_RUNS_C; r++) begin
      fs = int'(rand_bits(4)) % MAX_FS_DIV_C + 1;
      reg_write(REG_FS_DIV_O, fs);
      wait_valid(n); // first two strobes may follow the old period
      wait_valid(n);
      for (int k = 0; k < PERIOD_PULSES_C; k++) begin
        wait_valid(n);
        check_value($sformatf("strobe spacing, fs_div %0d", fs), n, (fs > 1) ? fs : 1);
      end
    end
    finish_test("sampling_period", start);

    start = errors; // bypass
    reg_write(REG_CTRL_O, 32'h1);
    reg_write(REG_OSC_STEP_O, rand_bits(32));
    reg_write(REG_FS_DIV_O, int'(rand_bits(4)) % MAX_FS_DIV_C + 1);
    wait_valid(n);
    wait_valid(n);
    for (int k = 0; k < SAMPLES_C; k++) begin
      wait_valid(n);
      check_value("bypass output", 32'(filtered_waveform), 32'(m_x_last));
    end
    apb_transfer(1'b0, REG_Y_O, '0, got, y_model);
    check_value("y in bypass", got, y_model);
    finish_test("bypass", start);

    start = errors; // filtering, last run uses full width coefficients
    reg_write(REG_CTRL_O, 32'h0);
    for (int r = 0; r < FILTER_RUNS_C; r++) begin
      for (int i = 3; i < 8; i++) begin
        reg_write(CFG_OFFSETS_C[i], rand_coef((r == FILTER_RUNS_C - 1) ? COEF_WIDTH_C : 15));
      end
      reg_write(REG_OSC_STEP_O, rand_bits(28));
      reg_write(REG_FS_DIV_O, int'(rand_bits(4)) % MAX_FS_DIV_C + 1);
      wait_valid(n);
      for (int k = 0; k < SAMPLES_C; k++) begin
        wait_valid(n);
        check_value("filter output", 32'(filtered_waveform), 32'(m_y));
      end
    end
    finish_test("filtering", start);

    $display("tests run: %0d, passed: %0d, failed: %0d, check errors: %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
